/* filelist.f */
hdl/codes.sv
hdl/control.sv
hdl/sequencer.sv
hdl/regfile.sv
hdl/alu.sv
hdl/datapath.sv
hdl/cpu_top.sv
tests/mem_model.sv
tests/cpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tests/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

  import codes::*;

  localparam logic [31:0] START_PC  = 32'h0000_0040;
  localparam logic [31:0] DATA_BASE = 32'h0000_0800;

  logic        clk = 1'b0;
  logic        rst_n = 1'b0;
  mem_req_t    mem_req;
  logic        mem_req_valid;
  logic        mem_req_ready;
  logic [31:0] mem_rdata;

  logic [31:0] ref_regs [32];
  logic [31:0] ref_hi;
  logic [31:0] ref_lo;
  logic [31:0] ref_data [logic [31:0]];
  mem_req_t    expect_q [$];
  logic [31:0] asm_pc;
  int          instr_count = 0;
  int          slot = 0;
  logic        done = 1'b0;
  logic        prev_stall = 1'b0;
  mem_req_t    prev_req;

  cpu_top #(
    .RESET_PC (START_PC)
  ) cpu_top_inst (
    .clk_i           (clk),
    .rst_n_i         (rst_n),
    .mem_req_o       (mem_req),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_ready_i (mem_req_ready),
    .mem_rdata_i     (mem_rdata)
  );

  mem_model mem_model_inst (
    .clk_i       (clk),
    .req_i       (mem_req),
    .req_valid_i (mem_req_valid),
    .req_ready_o (mem_req_ready),
    .rdata_o     (mem_rdata)
  );

  always #10 clk = ~clk;

  task automatic halt_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped at the first failure.");
  endtask

  task automatic abort_run(input string msg);
    $display("** Error at %0t: %s", $time, msg);
    halt_on_failure();
  endtask

  task automatic report_mismatch(input string name, input logic [64:0] got,
                                 input logic [64:0] exp);
    $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
    halt_on_failure();
  endtask

  function automatic logic [31:0] sext(input logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

  function automatic logic [15:0] preset_off();
    return 16'(4 * ($urandom % 8));
  endfunction

  function automatic logic [15:0] stored_off();
    return 16'(32'h100 + 4 * ($urandom % slot));
  endfunction

  // Places one word at the assembly PC and expects its fetch.
  task automatic emit(input logic [31:0] word);
    mem_model_inst.write_word(asm_pc, word);
    expect_q.push_back({asm_pc, 32'h0, 1'b0});
    asm_pc = asm_pc + 32'd4;
    instr_count++;
  endtask

  task automatic set_reg(input int r, input logic [31:0] value);
    if (r != 0) begin
      ref_regs[r] = value;
    end
  endtask

  task automatic alu_imm(input opcode_t op, input int rt, input int rs, input logic [15:0] imm);
    logic [31:0] a;
    logic [31:0] r;
    a = ref_regs[rs];
    emit({op, 5'(rs), 5'(rt), imm});
    case (op)
      OP_ANDI:  r = a & {16'h0, imm};
      OP_ORI:   r = a | {16'h0, imm};
      OP_XORI:  r = a ^ {16'h0, imm};
      OP_SLTI:  r = {31'h0, $signed(a) < $signed(sext(imm))};
      OP_SLTIU: r = {31'h0, a < sext(imm)};
      default:  r = a + sext(imm); // ADDIU.
    endcase
    set_reg(rt, r);
  endtask

  task automatic special_op(input func_t fn, input int rd, input int rs, input int rt);
    logic [31:0] a;
    logic [31:0] b;
    a = ref_regs[rs];
    b = ref_regs[rt];
    emit({OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'h0, fn});
    case (fn)
      FUNC_ADDU: set_reg(rd, a + b);
      FUNC_SUBU: set_reg(rd, a - b);
      FUNC_AND:  set_reg(rd, a & b);
      FUNC_OR:   set_reg(rd, a | b);
      FUNC_XOR:  set_reg(rd, a ^ b);
      FUNC_SLT:  set_reg(rd, {31'h0, $signed(a) < $signed(b)});
      FUNC_SLTU: set_reg(rd, {31'h0, a < b});
      FUNC_MTHI: ref_hi = a;
      FUNC_MTLO: ref_lo = a;
      FUNC_MFHI: set_reg(rd, ref_hi);
      FUNC_MFLO: set_reg(rd, ref_lo);
      default: begin
        // The skipped PC+4 after JR holds a store of $zero.
        mem_model_inst.write_word(asm_pc, {OP_SW, 5'd0, 5'd0, 16'h0});
        asm_pc = a;
      end
    endcase
  endtask

  task automatic load_store(input opcode_t op, input int rt, input int rs,
                            input logic [15:0] imm);
    logic [31:0] addr;
    addr = ref_regs[rs] + sext(imm);
    emit({op, 5'(rs), 5'(rt), imm});
    if (op == OP_SW) begin
      expect_q.push_back({addr, ref_regs[rt], 1'b1});
      ref_data[addr] = ref_regs[rt];
    end else begin
      expect_q.push_back({addr, 32'h0, 1'b0});
      set_reg(rt, ref_data[addr]);
    end
  endtask

  task automatic store(input int rt);
    load_store(OP_SW, rt, 1, 16'(32'h100 + 4 * slot));
    slot++;
  endtask

  task automatic build_program();
    opcode_t imm_ops [6] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU};
    func_t   reg_ops [7] = '{FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR,
                             FUNC_SLT, FUNC_SLTU};
    for (int i = 0; i < 8; i++) begin
      ref_data[DATA_BASE + 32'(4 * i)] = $urandom;
      mem_model_inst.write_word(DATA_BASE + 32'(4 * i), ref_data[DATA_BASE + 32'(4 * i)]);
    end
    alu_imm(OP_ADDIU, 1, 0, DATA_BASE[15:0]); // Base register.
    for (int round = 0; round < 2; round++) begin
      foreach (imm_ops[k]) begin
        if (round == 0) begin
          load_store(OP_LW, 2, 1, preset_off());
        end else begin
          alu_imm(OP_ADDIU, 2, 0, 16'($urandom));
        end
        alu_imm(imm_ops[k], 3, 2, 16'($urandom));
        store(3);
      end
    end
    foreach (reg_ops[k]) begin
      load_store(OP_LW, 4, 1, preset_off());
      load_store(OP_LW, 5, 1, stored_off());
      special_op(reg_ops[k], 6, 4, 5);
      store(6);
    end
    special_op(FUNC_ADDU, 0, 4, 5);
    store(0);
    alu_imm(OP_ORI, 0, 4, 16'($urandom));
    store(0);
    load_store(OP_LW, 8, 1, stored_off());
    load_store(OP_LW, 9, 1, preset_off());
    special_op(FUNC_MTHI, 0, 8, 0);
    special_op(FUNC_MTLO, 0, 9, 0);
    special_op(FUNC_MFHI, 10, 0, 0);
    special_op(FUNC_MFLO, 11, 0, 0);
    store(10);
    store(11);
    alu_imm(OP_ADDIU, 12, 0, 16'(asm_pc + 32'h40)); // Jump target.
    special_op(FUNC_JR, 0, 12, 0);
    alu_imm(OP_ADDIU, 13, 12, 16'($urandom));
    store(13);
  endtask

  // Every transfer is compared in order with the expected list.
  always @(posedge clk) begin : bus_monitor
    mem_req_t exp_req;
    if (!rst_n) begin
      assert (!mem_req_valid) else abort_run("memory request valid during reset");
    end else if (!done) begin
      if (prev_stall) begin
        assert (mem_req_valid) else abort_run("request valid dropped before acceptance");
        assert (mem_req == prev_req) else report_mismatch("mem_req_o", mem_req, prev_req);
      end
      if (mem_req_valid && mem_req_ready) begin
        exp_req = expect_q.pop_front();
        assert (mem_req.we == exp_req.we)
          else report_mismatch("mem_req_o.we", 65'(mem_req.we), 65'(exp_req.we));
        assert (mem_req.addr == exp_req.addr)
          else report_mismatch("mem_req_o.addr", 65'(mem_req.addr), 65'(exp_req.addr));
        if (exp_req.we) begin
          assert (mem_req.wdata == exp_req.wdata)
            else report_mismatch("mem_req_o.wdata", 65'(mem_req.wdata), 65'(exp_req.wdata));
        end
        if (expect_q.size() == 0) begin
          done <= 1'b1;
        end
      end
    end
    prev_stall <= rst_n && mem_req_valid && !mem_req_ready;
    prev_req   <= mem_req;
  end

  initial begin
    void'($urandom(32'h6851d131));
    asm_pc = START_PC;
    ref_hi = '0;
    ref_lo = '0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = '0;
    end
    mem_model_inst.fill_pattern();
    build_program();
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    wait (done);
    @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

  // Three cycles per instruction and four times that for stalls.
  initial begin
    wait (rst_n);
    repeat (instr_count * 3 * 4) @(posedge clk);
    abort_run($sformatf("program did not finish within %0d cycles", instr_count * 12));
  end

endmodule

/* tests/mem_model.sv */
`timescale 1ns/10ps

module mem_model #(
  parameter int WORDS = 1024
) (
  input  logic            clk_i,
  input  codes::mem_req_t req_i,
  input  logic            req_valid_i,
  output logic            req_ready_o,
  output logic [31:0]     rdata_o
);

  localparam int AW = $clog2(WORDS);

  logic [31:0]   mem_q [WORDS];
  logic [AW-1:0] index;
  logic          ready_q = 1'b0;
  logic [31:0]   rdata_q = '0;

  assign index       = req_i.addr[AW+1:2];
  assign req_ready_o = ready_q;
  assign rdata_o     = rdata_q;

  task automatic fill_pattern();
    for (int i = 0; i < WORDS; i++) begin
      mem_q[i] = 32'hbad0_0000 ^ (32'(i) << 2); // Byte address in the low bits.
    end
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    mem_q[addr[AW+1:2]] = data;
  endtask

  // Roughly one stall cycle in three.
  always @(negedge clk_i) begin
    ready_q <= ($urandom % 3) != 0;
  end

  // Read data holds until the next accepted request.
  always @(posedge clk_i) begin
    if (req_valid_i && ready_q) begin
      if (req_i.we) begin
        mem_q[index] = req_i.wdata;
      end else begin
        rdata_q <= mem_q[index];
      end
    end
  end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
  parameter logic [31:0] RESET_PC = codes::RESET_PC
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  output codes::mem_req_t mem_req_o,
  output logic            mem_req_valid_o,
  input  logic            mem_req_ready_i,
  input  logic [31:0]     mem_rdata_i
);

  import codes::*;

  state_t            state;
  logic              step;
  opcode_t           opcode;
  func_t             funct;
  logic              pc_write_en;
  logic              ir_write_en;
  logic              ram_write_en;
  logic              ram_read_en;
  logic              src_b_sel;
  logic              ram_addr_sel;
  logic              regfile_writedata_sel;
  logic              regfile_write_en;
  logic              hi_write_en;
  logic              lo_write_en;
  regfile_addr_sel_t regfile_addr_3_sel;

  sequencer sequencer_inst (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .mem_req_valid_i (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .state_o         (state),
    .step_o          (step)
  );

  control control_inst (
    .state_i                 (state),
    .opcode_i                (opcode),
    .function_i              (funct),
    .pc_write_en_o           (pc_write_en),
    .ir_write_en_o           (ir_write_en),
    .ram_write_en_o          (ram_write_en),
    .ram_read_en_o           (ram_read_en),
    .src_b_sel_o             (src_b_sel),
    .ram_addr_sel_o          (ram_addr_sel),
    .regfile_writedata_sel_o (regfile_writedata_sel),
    .regfile_write_en_o      (regfile_write_en),
    .hi_write_en_o           (hi_write_en),
    .lo_write_en_o           (lo_write_en),
    .regfile_addr_3_sel_o    (regfile_addr_3_sel)
  );

  datapath #(
    .RESET_PC (RESET_PC)
  ) datapath_inst (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .step_i                  (step),
    .state_i                 (state),
    .pc_write_en_i           (pc_write_en),
    .ir_write_en_i           (ir_write_en),
    .ram_write_en_i          (ram_write_en),
    .ram_read_en_i           (ram_read_en),
    .src_b_sel_i             (src_b_sel),
    .ram_addr_sel_i          (ram_addr_sel),
    .regfile_writedata_sel_i (regfile_writedata_sel),
    .regfile_write_en_i      (regfile_write_en),
    .hi_write_en_i           (hi_write_en),
    .lo_write_en_i           (lo_write_en),
    .regfile_addr_3_sel_i    (regfile_addr_3_sel),
    .mem_rdata_i             (mem_rdata_i),
    .mem_req_o               (mem_req_o),
    .mem_req_valid_o         (mem_req_valid_o),
    .opcode_o                (opcode),
    .function_o              (funct)
  );

endmodule

/* hdl/datapath.sv */
`timescale 1ns/10ps

module datapath #(
  parameter logic [31:0] RESET_PC = codes::RESET_PC
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     step_i,
  input  codes::state_t            state_i,
  input  logic                     pc_write_en_i,
  input  logic                     ir_write_en_i,
  input  logic                     ram_write_en_i,
  input  logic                     ram_read_en_i,
  input  logic                     src_b_sel_i,
  input  logic                     ram_addr_sel_i,
  input  logic                     regfile_writedata_sel_i,
  input  logic                     regfile_write_en_i,
  input  logic                     hi_write_en_i,
  input  logic                     lo_write_en_i,
  input  codes::regfile_addr_sel_t regfile_addr_3_sel_i,
  input  logic [31:0]              mem_rdata_i,
  output codes::mem_req_t          mem_req_o,
  output logic                     mem_req_valid_o,
  output codes::opcode_t           opcode_o,
  output codes::func_t             function_o
);

  import codes::*;

  logic [31:0] pc_q;
  logic [31:0] pc_next;
  logic [31:0] hi_q;
  logic [31:0] lo_q;
  instr_u      ir_q;
  instr_u      instr;
  logic        is_jr;
  logic [4:0]  rf_addr_3;
  logic [31:0] rf_rdata_1;
  logic [31:0] rf_rdata_2;
  logic [31:0] rf_wdata;
  logic [31:0] imm_sx;
  logic [31:0] src_b;
  logic [31:0] alu_result;

  // Fetched word is still on the read bus during EXEC1.
  assign instr      = (state_i == EXEC1) ? instr_u'(mem_rdata_i) : ir_q;
  assign opcode_o   = instr.rtype.op;
  assign function_o = instr.rtype.funct;

  assign imm_sx    = {{16{instr.itype.imm[15]}}, instr.itype.imm};
  assign src_b     = src_b_sel_i ? imm_sx : rf_rdata_2;
  assign rf_addr_3 = (regfile_addr_3_sel_i == REGFILE_ADDR_SEL_RD) ?
                     instr.rtype.rd : instr.rtype.rt;
  assign rf_wdata  = regfile_writedata_sel_i ? alu_result : mem_rdata_i; // Load data.

  regfile regfile_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .addr_1_i      (instr.rtype.rs),
    .addr_2_i      (instr.rtype.rt),
    .addr_3_i      (rf_addr_3),
    .write_data_i  (rf_wdata),
    .write_en_i    (regfile_write_en_i & step_i),
    .read_data_1_o (rf_rdata_1),
    .read_data_2_o (rf_rdata_2)
  );

  alu alu_inst (
    .instr_i  (instr),
    .src_a_i  (rf_rdata_1),
    .src_b_i  (src_b),
    .hi_i     (hi_q),
    .lo_i     (lo_q),
    .result_o (alu_result)
  );

  assign is_jr   = (instr.rtype.op == OP_SPECIAL) && (instr.rtype.funct == FUNC_JR);
  assign pc_next = is_jr ? rf_rdata_1 : pc_q + 32'd4;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else if (step_i && pc_write_en_i) begin
      pc_q <= pc_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (step_i && ir_write_en_i) begin
      ir_q <= instr;
    end
    if (step_i && hi_write_en_i) begin
      hi_q <= rf_rdata_1; // MTHI takes rs.
    end
    if (step_i && lo_write_en_i) begin
      lo_q <= rf_rdata_1;
    end
  end

  assign mem_req_o.addr  = ram_addr_sel_i ? alu_result : pc_q;
  assign mem_req_o.wdata = rf_rdata_2;
  assign mem_req_o.we    = ram_write_en_i;

  // No request until reset is released.
  assign mem_req_valid_o = rst_n_i & (ram_read_en_i | ram_write_en_i);

endmodule

/* hdl/alu.sv */
`timescale 1ns/10ps

module alu (
  input  codes::instr_u instr_i,
  input  logic [31:0]   src_a_i,
  input  logic [31:0]   src_b_i,
  input  logic [31:0]   hi_i,
  input  logic [31:0]   lo_i,
  output logic [31:0]   result_o
);

  import codes::*;

  logic [31:0] imm_zx;
  logic        lt_signed;
  logic        lt_unsigned;

  // Logical immediates are zero extended.
  assign imm_zx      = {16'b0, instr_i.itype.imm};
  assign lt_signed   = ($signed(src_a_i) < $signed(src_b_i));
  assign lt_unsigned = (src_a_i < src_b_i);

  always_comb begin
    case (instr_i.itype.op)
      OP_ANDI:  result_o = src_a_i & imm_zx;
      OP_ORI:   result_o = src_a_i | imm_zx;
      OP_XORI:  result_o = src_a_i ^ imm_zx;
      OP_SLTI:  result_o = {31'b0, lt_signed};
      OP_SLTIU: result_o = {31'b0, lt_unsigned};
      OP_SPECIAL: begin
        case (instr_i.rtype.funct)
          FUNC_SUBU: result_o = src_a_i - src_b_i;
          FUNC_AND:  result_o = src_a_i & src_b_i;
          FUNC_OR:   result_o = src_a_i | src_b_i;
          FUNC_XOR:  result_o = src_a_i ^ src_b_i;
          FUNC_SLT:  result_o = {31'b0, lt_signed};
          FUNC_SLTU: result_o = {31'b0, lt_unsigned};
          FUNC_MFHI: result_o = hi_i;
          FUNC_MFLO: result_o = lo_i;
          default:   result_o = src_a_i + src_b_i;
        endcase
      end
      default: result_o = src_a_i + src_b_i; // ADDIU and address add.
    endcase
  end

endmodule

/* hdl/regfile.sv */
`timescale 1ns/10ps

module regfile (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  addr_1_i,
  input  logic [4:0]  addr_2_i,
  input  logic [4:0]  addr_3_i,
  input  logic [31:0] write_data_i,
  input  logic        write_en_i,
  output logic [31:0] read_data_1_o,
  output logic [31:0] read_data_2_o
);

  logic [31:0] regs_q [32];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (write_en_i && (addr_3_i != 5'd0)) begin
      regs_q[addr_3_i] <= write_data_i;
    end
  end

  // $zero.
  assign read_data_1_o = (addr_1_i == 5'd0) ? '0 : regs_q[addr_1_i];
  assign read_data_2_o = (addr_2_i == 5'd0) ? '0 : regs_q[addr_2_i];

endmodule

/* hdl/sequencer.sv */
`timescale 1ns/10ps

module sequencer (
  input  logic          clk_i,
  input  logic          rst_n_i,
  input  logic          mem_req_valid_i,
  input  logic          mem_req_ready_i,
  output codes::state_t state_o,
  output logic          step_o
);

  import codes::*;

  state_t state_q;
  state_t state_d;

  // Hold while a request waits for ready.
  assign step_o = ~mem_req_valid_i | mem_req_ready_i;

  always_comb begin
    case (state_q)
      FETCH:   state_d = EXEC1;
      EXEC1:   state_d = EXEC2;
      default: state_d = FETCH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= FETCH;
    end else if (step_o) begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

endmodule

/* hdl/control.sv */
`timescale 1ns/10ps

module control (
  input  codes::state_t            state_i,
  input  codes::opcode_t           opcode_i,
  input  codes::func_t             function_i,
  output logic                     pc_write_en_o,
  output logic                     ir_write_en_o,
  output logic                     ram_write_en_o,
  output logic                     ram_read_en_o,
  output logic                     src_b_sel_o,
  output logic                     ram_addr_sel_o,
  output logic                     regfile_writedata_sel_o,
  output logic                     regfile_write_en_o,
  output logic                     hi_write_en_o,
  output logic                     lo_write_en_o,
  output codes::regfile_addr_sel_t regfile_addr_3_sel_o
);

  import codes::*;

  logic is_fetch;
  logic is_exec1;
  logic is_exec2;

  assign is_fetch = (state_i == FETCH);
  assign is_exec1 = (state_i == EXEC1);
  assign is_exec2 = (state_i == EXEC2);

  always_comb begin
    // Common to every instruction.
    pc_write_en_o           = is_exec2;
    ir_write_en_o           = is_exec1;
    ram_write_en_o          = 1'b0;
    ram_read_en_o           = is_fetch;
    src_b_sel_o             = 1'b0;
    ram_addr_sel_o          = 1'b0;
    regfile_writedata_sel_o = 1'b0;
    regfile_write_en_o      = 1'b0;
    hi_write_en_o           = 1'b0;
    lo_write_en_o           = 1'b0;
    regfile_addr_3_sel_o    = REGFILE_ADDR_SEL_RT;

    case (opcode_i)
      OP_SW: begin
        ram_write_en_o |= is_exec2;
        src_b_sel_o    |= is_exec2;
        ram_addr_sel_o |= is_exec2;
      end
      OP_LW: begin
        ram_read_en_o      |= is_exec1; // Data read at rs + imm.
        src_b_sel_o        |= is_exec1;
        ram_addr_sel_o     |= is_exec1;
        regfile_write_en_o |= is_exec2;
      end
      OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI, OP_SLTIU: begin
        regfile_write_en_o      |= is_exec2;
        src_b_sel_o             |= is_exec2;
        regfile_writedata_sel_o |= is_exec2;
      end
      OP_SPECIAL: begin
        case (function_i)
          FUNC_MTHI: hi_write_en_o = is_exec2;
          FUNC_MTLO: lo_write_en_o = is_exec2;
          FUNC_ADDU, FUNC_SUBU, FUNC_AND, FUNC_OR, FUNC_XOR, FUNC_SLT, FUNC_SLTU,
          FUNC_MFHI, FUNC_MFLO: begin
            regfile_write_en_o      = is_exec2;
            regfile_writedata_sel_o = is_exec2;
            regfile_addr_3_sel_o    = REGFILE_ADDR_SEL_RD;
          end
          default: begin
            // JR only moves the PC.
          end
        endcase
      end
      default: begin
      end
    endcase
  end

endmodule

/* hdl/codes.sv */
package codes;

  typedef enum logic [1:0] {
    FETCH = 2'd0,
    EXEC1 = 2'd1,
    EXEC2 = 2'd2
  } state_t;

  // Primary opcode, instruction bits 31:26.
  typedef enum logic [5:0] {
    OP_SPECIAL = 6'h00,
    OP_ADDIU   = 6'h09,
    OP_SLTI    = 6'h0a,
    OP_SLTIU   = 6'h0b,
    OP_ANDI    = 6'h0c,
    OP_ORI     = 6'h0d,
    OP_XORI    = 6'h0e,
    OP_LW      = 6'h23,
    OP_SW      = 6'h2b
  } opcode_t;

  // SPECIAL function field, bits 5:0.
  typedef enum logic [5:0] {
    FUNC_JR   = 6'h08,
    FUNC_MFHI = 6'h10,
    FUNC_MTHI = 6'h11,
    FUNC_MFLO = 6'h12,
    FUNC_MTLO = 6'h13,
    FUNC_ADDU = 6'h21,
    FUNC_SUBU = 6'h23,
    FUNC_AND  = 6'h24,
    FUNC_OR   = 6'h25,
    FUNC_XOR  = 6'h26,
    FUNC_SLT  = 6'h2a,
    FUNC_SLTU = 6'h2b
  } func_t;

  typedef enum logic {
    REGFILE_ADDR_SEL_RT = 1'b0,
    REGFILE_ADDR_SEL_RD = 1'b1
  } regfile_addr_sel_t;

  typedef struct packed {
    opcode_t    op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    func_t      funct;
  } r_type_t;

  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_type_t;

  // One IR word, read in either layout.
  typedef union packed {
    r_type_t rtype;
    i_type_t itype;
  } instr_u;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        we;
  } mem_req_t;

  localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage
